// ==== fp_add.f ====
+incdir+dv
verilog/fp_add_pkg.sv
verilog/fp_lzc.sv
verilog/fp_align.sv
verilog/fp_mant_add.sv
verilog/fp_normalize.sv
verilog/fp_round.sv
verilog/fp_add.sv
dv/fp_add_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fp_add testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --top-module fp_add_tb -f fp_add.f -o fp_add_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/fp_add_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// ==== dv/fp_add_model.svh ====
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// wide enough for a significand shifted up by the largest exponent
localparam int WIDE_W = 288;

// value of a word as an integer count of 2^-149 units
function automatic logic [WIDE_W-1:0] word_units(input fp_word_t w);
    logic [WIDE_W-1:0] sig;
    int                e;
    // subnormals share the scale of exponent 1
    e   = (w.exp == '0) ? 1 : int'(w.exp);
    sig = WIDE_W'({(w.exp != '0), w.frac});
    return sig << (e - 1);
endfunction

// exact sum of a and b, rounded once to nearest even
function automatic fp_word_t exact_round_add(input fp_word_t a, input fp_word_t b);
    logic [WIDE_W-1:0] ma;
    logic [WIDE_W-1:0] mb;
    logic [WIDE_W-1:0] m;
    logic [WIDE_W-1:0] rest;
    logic [WIDE_W-1:0] half;
    logic [FRAC_W+1:0] sig;
    logic              sign;
    int                p;
    int                e;
    fp_word_t          w;
    ma = word_units(a);
    mb = word_units(b);
    // sign-magnitude add on the common 2^-149 grid
    if (a.sign == b.sign) begin
        m    = ma + mb;
        sign = a.sign;
    end else if (ma >= mb) begin
        m    = ma - mb;
        sign = a.sign;
    end else begin
        m    = mb - ma;
        sign = b.sign;
    end
    w = '0;
    if (m == '0) begin
        // cancellation gives +0, two zeros of one sign keep that sign
        w.sign = (a.sign == b.sign) ? a.sign : 1'b0;
        return w;
    end
    p = 0;
    for (int i = 0; i < WIDE_W; i++) begin
        if (m[i]) begin
            p = i;
        end
    end
    w.sign = sign;
    if (p < FRAC_W) begin
        // below the normal range, exact on the grid
        w.frac = m[FRAC_W-1:0];
        return w;
    end
    // leading one at bit p is 2^(p-149), so the biased exponent is p-22
    e   = p - 22;
    sig = (FRAC_W + 2)'(m >> (p - FRAC_W));
    if (p > FRAC_W) begin
        rest = m & ((WIDE_W'(1) << (p - FRAC_W)) - WIDE_W'(1));
        half = WIDE_W'(1) << (p - FRAC_W - 1);
        if (rest > half || (rest == half && sig[0])) begin
            sig = sig + (FRAC_W + 2)'(1);
        end
    end
    // rounding carried out of the significand
    if (sig[FRAC_W+1]) begin
        sig = sig >> 1;
        e   = e + 1;
    end
    w.exp  = EXP_W'(e);
    w.frac = sig[FRAC_W-1:0];
    return w;
endfunction

`endif

// ==== dv/fp_add_tb.sv ====
`default_nettype none

module fp_add_tb
    import fp_add_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 200;
    localparam int LATENCY      = 5;
    localparam int DRAIN_LIMIT  = 20;
    // directed tests stay under 40 cycles each and a random pair takes at most 4
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * 40 + N_RANDOM * 4 + 200;

    logic     clk;
    logic     rstn;
    logic     valid;
    fp_word_t num_a;
    fp_word_t num_b;
    fp_word_t result;
    logic     ready;

    // expected words in issue order with the test that issued each one
    fp_word_t           exp_q[$];
    string              name_q[$];
    string              test_name = "reset";
    logic [LATENCY-1:0] valid_hist;
    int                 ready_count = 0;
    int                 err_result = 0;
    int                 err_ready = 0;
    int                 err_queue = 0;
    int                 err_flow = 0;

    `include "fp_add_model.svh"

    fp_add dut0 (
        .clk    (clk),
        .rstn   (rstn),
        .valid  (valid),
        .num_a  (num_a),
        .num_b  (num_b),
        .result (result),
        .ready  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // compare tasks and monitor
    ////////////////////////////////////////

    task automatic check_result(input string test, input fp_word_t expected,
                                input fp_word_t actual);
        if (actual !== expected) begin
            err_result++;
            $display("FAIL %s: expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic check_ready(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            err_ready++;
            $display("FAIL %s: expected ready %b actual %b", test, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge
    // ready must mirror valid from LATENCY edges back
    always @(negedge clk) begin
        if (!rstn) begin
            valid_hist <= '0;
        end else begin
            check_ready(test_name, valid_hist[LATENCY-1], ready);
            if (ready === 1'b1) begin
                ready_count++;
                if (exp_q.size() == 0) begin
                    err_queue++;
                    $display("%s: ready pulse with no result outstanding", test_name);
                end else begin
                    check_result(name_q.pop_front(), exp_q.pop_front(), result);
                end
            end
            valid_hist <= {valid_hist[LATENCY-2:0], valid};
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic apply_pair(input fp_word_t a, input fp_word_t b);
        @(posedge clk);
        valid <= 1'b1;
        num_a <= a;
        num_b <= b;
        exp_q.push_back(exact_round_add(a, b));
        name_q.push_back(test_name);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid <= 1'b0;
        end
    endtask

    // wait for every outstanding result up to DRAIN_LIMIT cycles
    task automatic drain();
        int waited;
        waited = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            err_flow++;
            $display("%s: %0d results never arrived", test_name, exp_q.size());
            exp_q.delete();
            name_q.delete();
        end
    endtask

    // normal operand with its exponent drawn from lo..hi
    function automatic fp_word_t random_operand(input int lo, input int hi);
        fp_word_t w;
        w.sign = 1'($urandom_range(0, 1));
        w.exp  = EXP_W'($urandom_range(hi, lo));
        w.frac = FRAC_W'($urandom());
        return w;
    endfunction

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_idle();
        int pulses;
        test_name = "reset_idle";
        repeat (8) begin
            @(negedge clk);
            check_result(test_name, '0, result);
        end
        pulses = ready_count;
        apply_pair(32'h3f80_0000, 32'h4000_0000);
        drain();
        if (ready_count - pulses != 1) begin
            err_flow++;
            $display("%s: one pair gave %0d ready pulses", test_name, ready_count - pulses);
        end
    endtask

    task automatic test_same_sign();
        test_name = "same_sign";
        // 1 + 1 carries into the exponent
        apply_pair(32'h3f80_0000, 32'h3f80_0000);
        apply_pair(32'h3fc0_0000, 32'h4020_0000);
        apply_pair(32'hbfa0_0000, 32'hc060_0000);
        // zero operand on either side
        apply_pair(32'h0000_0000, 32'h40a0_0000);
        apply_pair(32'h40e0_0000, 32'h0000_0000);
        apply_pair(32'h8000_0000, 32'hc120_0000);
        // exponent gap of 20
        apply_pair(32'h3f80_0000, 32'h3580_0000);
        drain();
    endtask

    task automatic test_opposite_sign();
        test_name = "opposite_sign";
        // cancellation down to one ulp in both orders
        apply_pair(32'h3f80_0001, 32'hbf80_0000);
        apply_pair(32'hbf80_0000, 32'h3f80_0001);
        apply_pair(32'h4000_0000, 32'hbfff_ffff);
        // x + (-x)
        apply_pair(32'h4040_0000, 32'hc040_0000);
        apply_pair(32'hc040_0000, 32'h4040_0000);
        apply_pair(32'h3f80_0000, 32'hc000_0000);
        apply_pair(32'hbf80_0000, 32'h4000_0000);
        apply_pair(32'h40a0_0000, 32'hbfc0_0000);
        apply_pair(32'hc120_0000, 32'h3dcc_cccd);
        // cancellation below the normal range clamps the exponent to zero
        apply_pair(32'h0080_0001, 32'h8080_0000);
        drain();
    endtask

    task automatic test_rounding();
        test_name = "rounding";
        // half an ulp stays with an even lsb and goes up with an odd one
        apply_pair(32'h3f80_0000, 32'h3380_0000);
        apply_pair(32'h3f80_0001, 32'h3380_0000);
        apply_pair(32'hbf80_0001, 32'hb380_0000);
        // guard plus sticky
        apply_pair(32'h3f80_0000, 32'h33a0_0000);
        // quarter ulp
        apply_pair(32'h3f80_0000, 32'h3300_0000);
        // all-ones fraction rounds into the exponent
        apply_pair(32'h3fff_ffff, 32'h3380_0000);
        apply_pair(32'h3f80_0000, 32'hb300_0000);
        drain();
    endtask

    task automatic test_random_stream();
        fp_word_t a;
        fp_word_t b;
        int       lo;
        int       hi;
        test_name = "random_stream";
        for (int i = 0; i < N_RANDOM; i++) begin
            a  = random_operand(100, 150);
            // keep the exponent gap within 20
            lo = (int'(a.exp) - 20 < 100) ? 100 : int'(a.exp) - 20;
            hi = (int'(a.exp) + 20 > 150) ? 150 : int'(a.exp) + 20;
            b  = random_operand(lo, hi);
            apply_pair(a, b);
            // second half leaves random gaps in valid
            if (i >= N_RANDOM / 2 && $urandom_range(0, 2) == 0) begin
                idle_cycles(int'($urandom_range(3, 1)));
            end
        end
        drain();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(95540));
        rstn  <= 1'b0;
        valid <= 1'b0;
        num_a <= '0;
        num_b <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        test_reset_idle();
        test_same_sign();
        test_opposite_sign();
        test_rounding();
        test_random_stream();
        $display("errors: result %0d, ready %0d, queue %0d, flow %0d",
                 err_result, err_ready, err_queue, err_flow);
        if (err_result + err_ready + err_queue + err_flow == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fp_add.sv ====
`default_nettype none

// five-stage single-precision adder, one pair per clock
// result and ready follow a valid input by exactly 5 cycles
module fp_add
    import fp_add_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     valid,
    input  fp_word_t num_a,
    input  fp_word_t num_b,
    output fp_word_t result,
    output logic     ready
);

    // stage payloads, valid rides inside each struct
    align_t aligned;
    sum_t   sum;
    norm_t  norm;

    // stages 1 and 2
    fp_align u_align (
        .clk     (clk),
        .rstn    (rstn),
        .valid   (valid),
        .num_a   (num_a),
        .num_b   (num_b),
        .aligned (aligned)
    );

    // stage 3
    fp_mant_add u_mant_add (
        .clk     (clk),
        .rstn    (rstn),
        .aligned (aligned),
        .sum     (sum)
    );

    // stage 4
    fp_normalize u_normalize (
        .clk  (clk),
        .rstn (rstn),
        .sum  (sum),
        .norm (norm)
    );

    // stage 5, result word comes out already packed
    fp_round u_round (
        .clk    (clk),
        .rstn   (rstn),
        .norm   (norm),
        .result (result),
        .ready  (ready)
    );

endmodule

`default_nettype wire

// ==== verilog/fp_round.sv ====
`default_nettype none

module fp_round
    import fp_add_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  norm_t    norm,
    output fp_word_t result,
    output logic     ready
);

    logic            round_up;
    logic [FRAC_W:0] rounded;
    logic            carry;
    fp_word_t        word_d;

    ////////////////////////////////////////
    // stage 5: round to nearest even
    ////////////////////////////////////////

    // above half, or exactly half with an odd lsb
    assign round_up = norm.guard & (norm.lsb | norm.round | norm.sticky);

    // one spare bit on top catches the carry of an all-ones fraction
    assign rounded  = {1'b0, norm.frac} + {{FRAC_W{1'b0}}, round_up};
    assign carry    = rounded[FRAC_W];

    always_comb begin
        word_d.sign = norm.sign;
        // carry gives 10.0..0, shifted back to 1.0..0 the fraction is zero
        // and the exponent steps up by one
        word_d.frac = rounded[FRAC_W-1:0];
        word_d.exp  = norm.exp + EXP_W'(carry);
    end

    // result holds between pulses
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
            ready  <= 1'b0;
        end else begin
            ready <= norm.valid;
            if (norm.valid) begin
                result <= word_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fp_normalize.sv ====
`default_nettype none

module fp_normalize
    import fp_add_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  sum_t  sum,
    output norm_t norm
);

    // lsb position once the leading one sits at ADD_W-2
    localparam int LSB_POS = ADD_W - FRAC_W - 2;

    logic               neg;
    logic [ADD_W-1:0]   mag;
    logic [LZC_W-1:0]   mag_pad;
    logic [SHIFT_W-1:0] lz;
    logic               clamp;
    logic [SHIFT_W-1:0] shift;
    logic [ADD_W-1:0]   shifted;
    norm_t              norm_d;

    ////////////////////////////////////////
    // stage 4: normalize
    ////////////////////////////////////////

    // magnitude of the two's complement sum
    assign neg     = sum.frac_sum[ADD_W-1];
    assign mag     = neg ? (~sum.frac_sum + ADD_W'(1)) : sum.frac_sum;
    assign mag_pad = {mag, {(LZC_W - ADD_W){1'b0}}};

    fp_lzc #(
        .WIDTH (LZC_W)
    ) u_lzc (
        .value (mag_pad),
        .count (lz)
    );

    // mag msb is always clear, so lz is at least 1
    // lz-1 at or past the exponent would go below exponent 1
    assign clamp   = EXP_W'(lz) > sum.exp;
    // on a clamp exp < lz, so it fits the shift width
    assign shift   = clamp ? SHIFT_W'(sum.exp) : (lz - SHIFT_W'(1));
    assign shifted = mag << shift;

    always_comb begin
        norm_d.valid  = sum.valid;
        // exponent 1 still shows its leading one, smaller means underflow
        if (mag == '0) begin
            norm_d.exp = '0;
        end else if (clamp) begin
            norm_d.exp = EXP_W'(shifted[ADD_W-2]);
        end else begin
            norm_d.exp = sum.exp + EXP_W'(1) - EXP_W'(shift);
        end
        // result sign from the operand signs and the sign of the difference
        case (sum.sign_ab)
            2'b00:   norm_d.sign = 1'b0;
            2'b11:   norm_d.sign = 1'b1;
            default: norm_d.sign = neg;
        endcase
        // fraction below the leading one, then the rounding bits
        norm_d.frac   = shifted[ADD_W-3 -: FRAC_W];
        norm_d.lsb    = shifted[LSB_POS];
        norm_d.guard  = shifted[LSB_POS-1];
        norm_d.round  = shifted[LSB_POS-2];
        norm_d.sticky = |shifted[LSB_POS-3:0];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            norm <= '0;
        end else begin
            norm <= norm_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fp_mant_add.sv ====
`default_nettype none

module fp_mant_add
    import fp_add_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  align_t aligned,
    output sum_t   sum
);

    sum_t sum_d;

    ////////////////////////////////////////
    // stage 3: fraction add or subtract
    ////////////////////////////////////////

    always_comb begin
        sum_d.valid   = aligned.valid;
        sum_d.sign_ab = aligned.sign_ab;
        sum_d.exp     = aligned.exp;
        // top bit becomes the sign of a difference, next one holds an add carry
        case (aligned.op)
            OP_A_SUB_B: sum_d.frac_sum = aligned.frac_a - aligned.frac_b;
            OP_B_SUB_A: sum_d.frac_sum = aligned.frac_b - aligned.frac_a;
            default:    sum_d.frac_sum = aligned.frac_a + aligned.frac_b;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum <= '0;
        end else begin
            sum <= sum_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fp_align.sv ====
`default_nettype none

module fp_align
    import fp_add_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     valid,
    input  fp_word_t num_a,
    input  fp_word_t num_b,
    output align_t   aligned
);

    // decoded operands held between the two stages
    typedef struct packed {
        logic              valid;
        logic              sign_a;
        logic              sign_b;
        logic [EXP_W-1:0]  exp_a;
        logic [EXP_W-1:0]  exp_b;
        logic [FRAC_W:0]   sig_a;
        logic [FRAC_W:0]   sig_b;
        logic [EXP_W-1:0]  diff_ab;
        logic [EXP_W-1:0]  diff_ba;
        logic              a_gt_b;
    } dec_t;

    dec_t             dec_d;
    dec_t             dec_q;
    align_t           align_d;
    logic [ADD_W-1:0] frame_a;
    logic [ADD_W-1:0] frame_b;
    logic [EXP_W-1:0] diff;

    ////////////////////////////////////////
    // stage 1: decode and exponent compare
    ////////////////////////////////////////

    always_comb begin
        dec_d.valid   = valid;
        dec_d.sign_a  = num_a.sign;
        dec_d.sign_b  = num_b.sign;
        dec_d.exp_a   = num_a.exp;
        dec_d.exp_b   = num_b.exp;
        // hidden bit only for a nonzero exponent
        dec_d.sig_a   = {|num_a.exp, num_a.frac};
        dec_d.sig_b   = {|num_b.exp, num_b.frac};
        // both differences up front, the compare picks one next cycle
        dec_d.diff_ab = num_a.exp - num_b.exp;
        dec_d.diff_ba = num_b.exp - num_a.exp;
        dec_d.a_gt_b  = num_a.exp > num_b.exp;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_d;
        end
    end

    ////////////////////////////////////////
    // stage 2: alignment and operation
    ////////////////////////////////////////

    // place significands below the headroom, extension bits catch the shift
    assign frame_a = {2'b00, dec_q.sig_a, {FRAC_W{1'b0}}};
    assign frame_b = {2'b00, dec_q.sig_b, {FRAC_W{1'b0}}};
    assign diff    = dec_q.a_gt_b ? dec_q.diff_ab : dec_q.diff_ba;

    always_comb begin
        align_d.valid   = dec_q.valid;
        align_d.sign_ab = {dec_q.sign_a, dec_q.sign_b};
        // smaller exponent moves right, equal exponents leave both in place
        align_d.frac_a  = dec_q.a_gt_b ? frame_a : (frame_a >> diff);
        align_d.frac_b  = dec_q.a_gt_b ? (frame_b >> diff) : frame_b;
        align_d.exp     = dec_q.a_gt_b ? dec_q.exp_a : dec_q.exp_b;
        // same signs add magnitudes, otherwise positive minus negative
        case ({dec_q.sign_a, dec_q.sign_b})
            2'b01:   align_d.op = OP_A_SUB_B;
            2'b10:   align_d.op = OP_B_SUB_A;
            default: align_d.op = OP_A_ADD_B;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aligned <= '0;
        end else begin
            aligned <= align_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fp_lzc.sv ====
`default_nettype none

// leading-zero count, WIDTH must be a power of two
// count equals WIDTH when value is all zero
module fp_lzc
    import fp_add_pkg::*;
#(
    parameter int WIDTH = LZC_W
) (
    input  logic [WIDTH-1:0]        value,
    output logic [$clog2(WIDTH):0]  count
);

    localparam int CW = $clog2(WIDTH);

    generate
        if (WIDTH == 2) begin : g_leaf
            assign count = value[1] ? 2'd0 : (value[0] ? 2'd1 : 2'd2);
        end else begin : g_node
            localparam int HALF = WIDTH / 2;

            logic [CW-1:0] cnt_hi;
            logic [CW-1:0] cnt_lo;

            // split in halves, each half counts on its own
            fp_lzc #(.WIDTH(HALF)) u_hi (.value(value[WIDTH-1:HALF]), .count(cnt_hi));
            fp_lzc #(.WIDTH(HALF)) u_lo (.value(value[HALF-1:0]), .count(cnt_lo));

            // msb of a half count flags an all-zero half
            always_comb begin
                if (!cnt_hi[CW-1]) begin
                    count = {1'b0, cnt_hi};
                end else if (!cnt_lo[CW-1]) begin
                    // upper half empty, add HALF
                    count = {2'b01, cnt_lo[CW-2:0]};
                end else begin
                    count = {1'b1, {CW{1'b0}}};
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== verilog/fp_add_pkg.sv ====
`default_nettype none

package fp_add_pkg;

    // ieee single precision fields
    localparam int EXP_W   = 8;
    localparam int FRAC_W  = 23;

    // adder frame: 2 headroom bits, 24-bit significand, 23 extension bits
    localparam int ADD_W   = 2 * FRAC_W + 3;
    // leading-zero counter runs over the frame padded to a power of two
    localparam int LZC_W   = 1 << $clog2(ADD_W);
    localparam int SHIFT_W = $clog2(LZC_W) + 1;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp_word_t;

    // which fraction operation the signs call for
    typedef enum logic [1:0] {
        OP_A_ADD_B,
        OP_A_SUB_B,
        OP_B_SUB_A
    } add_op_e;

    // after alignment, both fractions share the larger exponent
    typedef struct packed {
        logic              valid;
        add_op_e           op;
        logic [1:0]        sign_ab;
        logic [EXP_W-1:0]  exp;
        logic [ADD_W-1:0]  frac_a;
        logic [ADD_W-1:0]  frac_b;
    } align_t;

    // frac_sum is two's complement, msb is the sign
    typedef struct packed {
        logic              valid;
        logic [1:0]        sign_ab;
        logic [EXP_W-1:0]  exp;
        logic [ADD_W-1:0]  frac_sum;
    } sum_t;

    // normalized word plus the bits the rounder needs
    typedef struct packed {
        logic              valid;
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
        logic              lsb;
        logic              guard;
        logic              round;
        logic              sticky;
    } norm_t;

endpackage

`default_nettype wire
